// File: common/rx_link_pkg.sv
// Serial receiver shared definitions
// Word width, alignment comma, startup delay and link control states

package rx_link_pkg;

    //******************************
    // Word format
    //******************************

    // Bits per deserialized word
    parameter int WORD_WIDTH = 10;

    // K28.5-like alignment pattern, never a valid data word
    parameter logic [WORD_WIDTH-1:0] COMMA_WORD = 10'b0011111010;

    //******************************
    // Startup
    //******************************

    // Clock cycles from reset release until the receive path is trusted
    parameter int READY_WAIT = 255;

    //******************************
    // Link control
    //******************************

    typedef enum logic [1:0] {
        WAIT_READY = 2'd0,  // Holding off until startup timer expires
        SEARCH     = 2'd1,  // Bitslipping until a comma word shows up
        LOCKED     = 2'd2   // Boundary found, held until reset
    } link_state_t;

endpackage

// File: common/rx_word_if.sv
// Deserialized word bus between receiver blocks
// Carries the word strobe, comma detect and bitslip request

`timescale 1ns/100ps

interface rx_word_if #(
    parameter int WIDTH = rx_link_pkg::WORD_WIDTH
);

    logic [WIDTH-1:0] word;       // Stable from one strobe to the next
    logic             word_valid; // One cycle per assembled word
    logic             is_comma;   // Word matches alignment pattern
    logic             bitslip;    // One-cycle boundary shift request

    // Shifter side
    modport deser (
        output word,
        output word_valid,
        input  bitslip
    );

    // Comma compare and output register
    modport capture (
        input  word,
        input  word_valid,
        output is_comma
    );

    // Alignment FSM
    modport ctrl (
        input  word_valid,
        input  is_comma,
        output bitslip
    );

endinterface

// File: deser/deser_shift.sv
// Serial to parallel shifter
// Packs one bit per clock into WIDTH-bit words, with bitslip on the word boundary

`timescale 1ns/100ps

module deser_shift #(
    parameter int WIDTH = rx_link_pkg::WORD_WIDTH
)(
    input  logic        clkGHz_clkbuf,
    input  logic        reset_buf_n,
    input  logic        enable_n,      // Low to pass serial data
    input  logic        data_i,
    rx_word_if.deser    word_bus
);

    localparam int CW = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic             bit_in;      // Gated serial bit
    logic [WIDTH-1:0] shift_q;     // Last WIDTH bits, newest in LSB
    logic [CW-1:0]    bit_cnt_q;   // Bits taken into current word
    logic             word_done;   // Last bit of word on this edge

    assign bit_in    = data_i & ~enable_n;          // Disabled input reads as zero
    assign word_done = (bit_cnt_q == CW'(WIDTH - 1)) && !word_bus.bitslip;

    //******************************
    // Data path
    //******************************

    always_ff @(posedge clkGHz_clkbuf) begin
        shift_q <= {shift_q[WIDTH-2:0], bit_in};    // Oldest bit ends up in MSB
        if (word_done) begin
            word_bus.word <= {shift_q[WIDTH-2:0], bit_in}; // Capture incl. current bit
        end
    end

    //******************************
    // Word counter
    //******************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q           <= '0;
            word_bus.word_valid <= 1'b0;
        end else begin
            word_bus.word_valid <= word_done;       // Strobe follows last bit
            if (word_bus.bitslip) begin
                bit_cnt_q <= bit_cnt_q;             // Drop one bit from the count
            end else if (word_done) begin
                bit_cnt_q <= '0;                    // Start next word
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rx_link.f --top-module tb_rx_link -o sim_rx_link

# The run may stop on an error, the log decides the result
./obj_dir/sim_rx_link > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: rx_link.f
common/rx_link_pkg.sv
common/rx_word_if.sv
deser/deser_shift.sv
src/startup_timer.sv
src/word_capture.sv
src/link_ctrl.sv
src/rx_link_top.sv
test/tb_clkgen.sv
test/rx_link_sva.sv
test/tb_rx_link.sv

// File: src/link_ctrl.sv
// Link control FSM
// Waits for startup, searches the word boundary by bitslip, then locks

`timescale 1ns/100ps

module link_ctrl (
    input  logic       clkGHz_clkbuf,
    input  logic       reset_buf_n,
    input  logic       ready,        // Startup delay expired
    rx_word_if.ctrl    word_bus,
    output logic       locked
);

    rx_link_pkg::link_state_t state_q;
    rx_link_pkg::link_state_t state_d;
    logic                     slip_d;   // Request a boundary shift

    //******************************
    // Next state
    //******************************

    always_comb begin
        state_d = state_q;
        slip_d  = 1'b0;
        unique case (state_q)
            rx_link_pkg::WAIT_READY: begin
                if (ready) begin
                    state_d = rx_link_pkg::SEARCH;      // Words now trusted
                end
            end
            rx_link_pkg::SEARCH: begin
                if (word_bus.word_valid) begin
                    if (word_bus.is_comma) begin
                        state_d = rx_link_pkg::LOCKED;  // Boundary found
                    end else begin
                        slip_d = 1'b1;                  // One slip per bad word
                    end
                end
            end
            rx_link_pkg::LOCKED: begin
                state_d = rx_link_pkg::LOCKED;          // No relock, held until reset
            end
            default: begin
                state_d = rx_link_pkg::WAIT_READY;
            end
        endcase
    end

    //******************************
    // State and bitslip registers
    //******************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q          <= rx_link_pkg::WAIT_READY;
            word_bus.bitslip <= 1'b0;
        end else begin
            state_q          <= state_d;
            word_bus.bitslip <= slip_d;                 // Pulse in cycle after strobe
        end
    end

    assign locked = (state_q == rx_link_pkg::LOCKED);

endmodule

// File: src/rx_link_top.sv
// Single-lane serial receiver top level
// Startup delay, word deserializer, comma alignment and data word output

`timescale 1ns/100ps

module rx_link_top #(
    parameter int               WIDTH       = rx_link_pkg::WORD_WIDTH,
    parameter logic [WIDTH-1:0] COMMA       = rx_link_pkg::COMMA_WORD,
    parameter int               WAIT_CYCLES = rx_link_pkg::READY_WAIT
)(
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,   // Async, active low
    input  logic             enable_n,      // Active-low serial enable
    input  logic             data_i,        // One bit per clock
    output logic [WIDTH-1:0] data_o,
    output logic             data_valid,
    output logic             ready,
    output logic             locked
);

    rx_word_if #(.WIDTH(WIDTH)) word_bus ();   // Shifter to capture and FSM

    deser_shift #(
        .WIDTH         (WIDTH)
    ) deser_shift_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .data_i        (data_i),
        .word_bus      (word_bus.deser)
    );

    startup_timer #(
        .WAIT_CYCLES   (WAIT_CYCLES)
    ) startup_timer_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .ready         (ready)
    );

    word_capture #(
        .WIDTH         (WIDTH),
        .COMMA         (COMMA)
    ) word_capture_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .locked        (locked),
        .word_bus      (word_bus.capture),
        .data_o        (data_o),
        .data_valid    (data_valid)
    );

    link_ctrl link_ctrl_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .ready         (ready),
        .word_bus      (word_bus.ctrl),
        .locked        (locked)
    );

endmodule

// File: src/startup_timer.sv
// Startup delay timer
// Raises ready a fixed number of cycles after reset and holds it

`timescale 1ns/100ps

module startup_timer #(
    parameter int WAIT_CYCLES = rx_link_pkg::READY_WAIT
)(
    input  logic clkGHz_clkbuf,
    input  logic reset_buf_n,
    output logic ready
);

    localparam int CW = $clog2(WAIT_CYCLES + 1);

    logic [CW-1:0] wait_cnt_q;  // Edges seen since reset release
    logic          reached;     // Final count on this edge

    assign reached = (wait_cnt_q == CW'(WAIT_CYCLES - 1));

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt_q <= '0;
            ready      <= 1'b0;
        end else begin
            if (!reached) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;    // Saturates at final count
            end
            if (reached) begin
                ready <= 1'b1;                      // Sticky until reset
            end
        end
    end

endmodule

// File: src/word_capture.sv
// Word capture stage
// Detects the comma and registers data words with a one-cycle valid pulse

`timescale 1ns/100ps

module word_capture #(
    parameter int               WIDTH = rx_link_pkg::WORD_WIDTH,
    parameter logic [WIDTH-1:0] COMMA = rx_link_pkg::COMMA_WORD
)(
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             locked,       // Boundary aligned
    rx_word_if.capture       word_bus,
    output logic [WIDTH-1:0] data_o,
    output logic             data_valid
);

    logic take_word;  // Data word arriving on a locked link

    //******************************
    // Comma detect
    //******************************

    assign word_bus.is_comma = (word_bus.word == COMMA);

    // Commas are idle fill once aligned
    assign take_word = word_bus.word_valid && locked && !word_bus.is_comma;

    //******************************
    // Output register
    //******************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o     <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= take_word;                // Single cycle per word
            if (take_word) begin
                data_o <= word_bus.word;            // Held until next data word
            end
        end
    end

endmodule

// File: test/rx_link_sva.sv
// Receiver protocol assertions
// Bound to the top level, watches bitslip, ready and the data strobe

`timescale 1ns/100ps

module rx_link_sva (
    input logic clkGHz_clkbuf,
    input logic reset_buf_n,
    input logic bitslip,       // Internal alignment request
    input logic ready,
    input logic locked,
    input logic data_valid
);

    // Boundary is frozen once locked
    no_slip_when_locked: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        locked |-> !bitslip)
        else $error("bitslip pulsed while locked");

    valid_needs_lock: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        data_valid |-> locked)
        else $error("data_valid raised without lock");

    // Startup flag is sticky
    ready_sticky: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        ready |=> ready)
        else $error("ready dropped without reset");

    valid_single_cycle: assert property (@(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        data_valid |=> !data_valid)
        else $error("data_valid held for two cycles");

endmodule

// File: test/tb_clkgen.sv
// Testbench clock and reset source
// 100 ns clock, reset held low for RESET_CYCLES and again on request

`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
)(
    input  logic reset_req,         // High forces reset, sampled on falling edge
    output logic clkGHz_clkbuf,
    output logic reset_buf_n
);

    int rst_cnt = 0;                // Falling edges since last request

    initial begin
        clkGHz_clkbuf = 1'b0;
        forever #(PERIOD_NS / 2) clkGHz_clkbuf = ~clkGHz_clkbuf;
    end

    always @(negedge clkGHz_clkbuf) begin
        if (reset_req) begin
            rst_cnt <= 0;                           // Restart reset window
        end else if (rst_cnt < RESET_CYCLES) begin
            rst_cnt <= rst_cnt + 1;
        end
    end

    // Release lands between rising edges
    assign reset_buf_n = !reset_req && (rst_cnt >= RESET_CYCLES);

endmodule

// File: test/tb_rx_link.sv
// Serial receiver testbench
// Random bit stream with comma alignment, data words, enable gaps and reset,
// checked against a bit-level word model

`timescale 1ns/100ps

module tb_rx_link;

    localparam int               WIDTH       = rx_link_pkg::WORD_WIDTH;
    localparam logic [WIDTH-1:0] COMMA       = rx_link_pkg::COMMA_WORD;
    localparam int               READY_WAIT  = rx_link_pkg::READY_WAIT;
    localparam int               DATA_WORDS  = 40;
    localparam int               LOCK_CYCLES = (WIDTH + 1) * (WIDTH + 1) + 3;
    localparam int               LOCK_WORDS  = READY_WAIT / WIDTH + 2 * (WIDTH + 1) + 2;

    logic             clkGHz_clkbuf;
    logic             reset_buf_n;
    logic             reset_req;
    logic             enable_n;
    logic             data_i;
    logic [WIDTH-1:0] data_o;
    logic             data_valid;
    logic             ready;
    logic             locked;

    logic [31:0]      lfsr_q;       // Galois LFSR state
    int               cyc;          // Falling edges seen
    int               since_rel;    // Cycles since reset release
    int               ready_cyc;    // Cycle ready was first seen
    int               lock_cyc;     // Cycle locked was first seen
    int               model_bits;   // Bits in current model word
    int               error_count;
    bit               capture_on;   // Model tracks aligned words
    logic [WIDTH-1:0] model_word;
    logic [WIDTH-1:0] exp_q[$];     // Expected data words in order
    int               due_q[$];     // Cycle each word must show up

    tb_clkgen clkgen_inst (
        .reset_req     (reset_req),
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n)
    );

    rx_link_top #(
        .WIDTH         (WIDTH),
        .COMMA         (COMMA),
        .WAIT_CYCLES   (READY_WAIT)
    ) rx_link_top_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .data_i        (data_i),
        .data_o        (data_o),
        .data_valid    (data_valid),
        .ready         (ready),
        .locked        (locked)
    );

    bind rx_link_top rx_link_sva rx_link_sva_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .bitslip       (word_bus.bitslip),
        .ready         (ready),
        .locked        (locked),
        .data_valid    (data_valid)
    );

    //******************************
    // Reporting
    //******************************

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    //******************************
    // Random bits
    //******************************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Right-shift Galois form
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};  // One step per bit
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    //******************************
    // Output monitor
    //******************************

    task automatic monitor_outputs();
        logic [WIDTH-1:0] exp_word;
        int               due;
        if (reset_buf_n !== 1'b1) begin
            since_rel = 0;                          // Restart startup timing
            ready_cyc = -1;
            lock_cyc  = -1;
        end else begin
            since_rel++;
            check_equal(32'(ready), (since_rel < READY_WAIT) ? 32'd0 : 32'd1, "ready");
            if (ready !== 1'b1) check_equal(32'(locked), 32'd0, "locked before ready");
            if (ready === 1'b1 && ready_cyc < 0) ready_cyc = cyc;
            if (locked === 1'b1 && lock_cyc < 0) lock_cyc = cyc;
            if (lock_cyc >= 0) check_equal(32'(locked), 32'd1, "locked held");
            if (data_valid === 1'b1) begin
                check_equal(32'(exp_q.size() > 0), 32'd1, "data_valid with no word due");
                exp_word = exp_q.pop_front();
                due      = due_q.pop_front();
                check_equal(32'(cyc), 32'(due), "data_valid cycle");
                check_equal(32'(data_o), 32'(exp_word), "data_o");
            end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
                check_equal(32'(data_valid), 32'd1, "missing data_valid");
            end
        end
    endtask

    //******************************
    // Serial driver and model
    //******************************

    task automatic send_bit(input logic b, input logic en_n);
        logic gated;
        @(negedge clkGHz_clkbuf);
        cyc++;
        monitor_outputs();
        data_i   <= b;                              // Taken on next rising edge
        enable_n <= en_n;
        gated    = b & ~en_n;                       // Disabled input reads zero
        if (capture_on) begin
            model_word = {model_word[WIDTH-2:0], gated};    // Oldest bit to MSB
            model_bits++;
            if (model_bits == WIDTH) begin
                model_bits = 0;
                if (model_word != COMMA) begin      // Commas are idle fill
                    exp_q.push_back(model_word);
                    due_q.push_back(cyc + 2);       // Word strobe plus output register
                end
            end
        end
    endtask

    task automatic send_word(input logic [WIDTH-1:0] w, input logic en_n);
        for (int i = WIDTH - 1; i >= 0; i--) begin
            send_bit(w[i], en_n);
        end
    endtask

    // Startup, alignment and data phase after one reset
    task automatic run_round();
        logic [31:0]      r;
        logic [WIDTH-1:0] w;
        int               n;
        capture_on = 1'b0;
        model_bits = 0;
        n = 0;
        while (reset_buf_n !== 1'b1) begin
            send_bit(1'b0, 1'b0);
            n++;
            if (n > 40) report_failure("reset was never released");
        end
        take_bits(4, r);
        n = r % WIDTH;                              // Leading bits before commas
        for (int i = 0; i < n; i++) begin
            take_bits(1, r);
            send_bit(r[0], 1'b0);
        end
        n = 0;
        while (lock_cyc < 0) begin
            send_word(COMMA, 1'b0);
            n++;
            if (n > LOCK_WORDS) report_failure("locked never rose on a comma stream");
        end
        if (lock_cyc - ready_cyc > LOCK_CYCLES) begin
            report_failure($sformatf("lock took %0d cycles after ready, limit %0d",
                                     lock_cyc - ready_cyc, LOCK_CYCLES));
        end
        capture_on = 1'b1;                          // Stream now on word boundary
        for (int i = 0; i < DATA_WORDS; i++) begin
            take_bits(2, r);
            if (r[1:0] == 2'd0) begin
                send_word(COMMA, 1'b0);
            end else if (r[1:0] == 2'd1) begin
                take_bits(WIDTH, r);
                send_word(r[WIDTH-1:0], 1'b1);      // Enable gap drops this data
            end else begin
                take_bits(WIDTH, r);
                w = r[WIDTH-1:0];
                if (w == COMMA) w = {w[WIDTH-1:1], ~w[0]};
                send_word(w, 1'b0);
            end
        end
        n = 0;
        while (due_q.size() > 0) begin
            send_word(COMMA, 1'b0);
            n++;
            if (n > 4) report_failure("data words still pending at end of round");
        end
        capture_on = 1'b0;
    endtask

    //******************************
    // Test sequence
    //******************************

    initial begin
        logic [31:0]      r;
        logic [WIDTH-1:0] w;
        int               n;
        data_i      = 1'b0;
        enable_n    = 1'b1;
        reset_req   = 1'b0;
        lfsr_q      = 32'hb782079f;
        cyc         = 0;
        since_rel   = 0;
        ready_cyc   = -1;
        lock_cyc    = -1;
        model_bits  = 0;
        model_word  = '0;
        capture_on  = 1'b0;
        error_count = 0;
        run_round();
        capture_on = 1'b1;                          // One more modelled data word
        take_bits(WIDTH, r);
        w = r[WIDTH-1:0] | WIDTH'(1);               // Set LSB so neither comma nor zero
        send_word(w, 1'b0);
        capture_on = 1'b0;
        n = 0;
        while (due_q.size() > 0) begin              // Run on to its data_valid cycle
            take_bits(1, r);
            send_bit(r[0], 1'b0);
            n++;
            if (n > 4) report_failure("data_valid missing before mid-stream reset");
        end
        reset_req <= 1'b1;                          // Lands while data_valid is high
        send_bit(1'b0, 1'b0);
        check_equal(32'(ready), 32'd0, "ready in reset");
        check_equal(32'(locked), 32'd0, "locked in reset");
        check_equal(32'(data_valid), 32'd0, "data_valid in reset");
        check_equal(32'(data_o), 32'd0, "data_o in reset");
        send_bit(1'b0, 1'b0);
        reset_req <= 1'b0;
        run_round();
        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule
